// ==== logic/ber_cfg_pkg.sv ====
// ------------------------------------------------------------
// widths and sizing for the ber meter
// ------------------------------------------------------------

package ber_cfg_pkg;

  // one popcount lane, matches the 36-bit adder primitive
  localparam int LANE_W = 36;

  // default error vector width
  // 100 bits -> three lanes, tree padded to four inputs
  localparam int DEF_BIT_ERR_W = 100;

  // per-frame error count width
  localparam int DEF_ERR_W = 16;

  // run total and frame counter width
  localparam int DEF_TOTAL_W = 32;

endpackage

// ==== logic/ber_meter_top.sv ====
// frame ber meter
// per-frame error count followed by run statistics
module ber_meter_top #(
  parameter int bit_err_w = ber_cfg_pkg::DEF_BIT_ERR_W,
  parameter int err_w     = ber_cfg_pkg::DEF_ERR_W,
  parameter int total_w   = ber_cfg_pkg::DEF_TOTAL_W
) (
  input  logic                        iclk,
  input  logic                        rst_n,
  input  logic                        clkena,
  input  ber_types_pkg::frame_ctl_s   ctl,
  input  logic [bit_err_w-1:0]        biterr,
  input  logic                        clear,
  output logic                        frame_val,
  output logic [err_w-1:0]            frame_err,
  output logic [total_w-1:0]          total_err,
  output logic [total_w-1:0]          frame_cnt
);

  // ------------------------------------------------------------
  // per-frame counter, 4 cycles eop to result with defaults
  // ------------------------------------------------------------

  biterr_cnt #(
    .bit_err_w (bit_err_w),
    .err_w     (err_w)
  ) u_cnt (
    .iclk      (iclk),
    .rst_n     (rst_n),
    .clkena    (clkena),
    .ctl       (ctl),
    .biterr    (biterr),
    .frame_val (frame_val),
    .frame_err (frame_err)
  );

  // ------------------------------------------------------------
  // run statistics, one more cycle
  // ------------------------------------------------------------

  ber_stats #(
    .err_w   (err_w),
    .total_w (total_w)
  ) u_stats (
    .iclk      (iclk),
    .rst_n     (rst_n),
    .clkena    (clkena),
    .clear     (clear),
    .frame_val (frame_val),
    .frame_err (frame_err),
    .total_err (total_err),
    .frame_cnt (frame_cnt)
  );

endmodule

// ==== logic/ber_stats.sv ====
// run statistics: saturating error total and frame count
module ber_stats #(
  parameter int err_w   = 16,
  parameter int total_w = 32
) (
  input  logic               iclk,
  input  logic               rst_n,
  input  logic               clkena,
  input  logic               clear,
  input  logic               frame_val,
  input  logic [err_w-1:0]   frame_err,
  output logic [total_w-1:0] total_err,
  output logic [total_w-1:0] frame_cnt
);

  // one extra bit catches the carry out
  logic [total_w:0]   total_sum;
  logic [total_w-1:0] total_nxt;
  logic [total_w-1:0] cnt_nxt;

  // ------------------------------------------------------------
  // saturating next values
  // ------------------------------------------------------------

  assign total_sum = {1'b0, total_err} + (total_w + 1)'(frame_err);
  assign total_nxt = total_sum[total_w] ? '1 : total_sum[total_w-1:0];

  // stop at all ones
  assign cnt_nxt = (&frame_cnt) ? frame_cnt : frame_cnt + 1'b1;

  // ------------------------------------------------------------
  // registers
  // ------------------------------------------------------------

  always_ff @(posedge iclk or negedge rst_n) begin
    if (!rst_n) begin
      total_err <= '0;
      frame_cnt <= '0;
    end else if (clkena) begin
      if (clear) begin
        // a result landing with clear counts as the first frame
        total_err <= frame_val ? total_w'(frame_err) : '0;
        frame_cnt <= frame_val ? total_w'(1) : '0;
      end else if (frame_val) begin
        total_err <= total_nxt;
        frame_cnt <= cnt_nxt;
      end
    end
  end

  // total only goes down through an enabled clear
  a_total_monotonic : assert property (
    @(posedge iclk) disable iff (!rst_n)
    !($past(clear) && $past(clkena)) |-> total_err >= $past(total_err)
  );

endmodule

// ==== logic/ber_types_pkg.sv ====
// ------------------------------------------------------------
// frame control carried alongside data through the pipeline
// ------------------------------------------------------------

package ber_types_pkg;

  // val qualifies the word
  // sop / eop only meaningful with val set
  // sop and eop may both be set on a one-word frame
  typedef struct packed {
    logic val;
    logic sop;
    logic eop;
  } frame_ctl_s;

endpackage

// ==== logic/biterr_adder_tree.sv ====
// pipelined binary adder tree
// 2**depth inputs, one register per level, depth cycles total
module biterr_adder_tree #(
  parameter int err_w = 16,
  parameter int depth = 2
) (
  input  logic                        iclk,
  input  logic                        rst_n,
  input  logic                        clkena,
  input  ber_types_pkg::frame_ctl_s   ctl_in,
  input  logic [err_w-1:0]            err_in [2**depth],
  output ber_types_pkg::frame_ctl_s   ctl_out,
  output logic [err_w-1:0]            sum
);

  genvar l;

  // ------------------------------------------------------------
  // tree levels
  // ------------------------------------------------------------

  for (l = 0; l < depth; l++) begin : g_lvl
    // level l halves the number of terms
    localparam int n_out = 2 ** (depth - l - 1);

    logic [err_w-1:0]          din  [2*n_out];
    logic [err_w-1:0]          dout [n_out];
    ber_types_pkg::frame_ctl_s cin;
    ber_types_pkg::frame_ctl_s cout;

    // first level eats the tree inputs, later ones the level before
    if (l == 0) begin : g_src_in
      assign din = err_in;
      assign cin = ctl_in;
    end else begin : g_src_lvl
      assign din = g_lvl[l-1].dout;
      assign cin = g_lvl[l-1].cout;
    end

    // pair adders
    always_ff @(posedge iclk) begin
      if (clkena) begin
        for (int n = 0; n < n_out; n++) begin
          dout[n] <= din[2*n] + din[2*n+1];
        end
      end
    end

    // control follows the data one level per cycle
    always_ff @(posedge iclk or negedge rst_n) begin
      if (!rst_n) begin
        cout <= '0;
      end else if (clkena) begin
        cout <= cin;
      end
    end
  end

  // ------------------------------------------------------------
  // root
  // ------------------------------------------------------------

  // single input tree is just a wire
  if (depth == 0) begin : g_pass
    assign sum     = err_in[0];
    assign ctl_out = ctl_in;
  end else begin : g_root
    assign sum     = g_lvl[depth-1].dout[0];
    assign ctl_out = g_lvl[depth-1].cout;
  end

  // strobes must not lose their val on the way through the lanes and levels
  a_ctl_out_qualified : assert property (
    @(posedge iclk) disable iff (!rst_n)
    (ctl_out.sop || ctl_out.eop) |-> ctl_out.val
  );

endmodule

// ==== logic/biterr_cnt.sv ====
// wide error vector -> per-frame error count
// lanes (1 cycle) + adder tree (depth) + accumulator (1)
module biterr_cnt #(
  parameter int bit_err_w = 100,
  parameter int err_w     = 16
) (
  input  logic                        iclk,
  input  logic                        rst_n,
  input  logic                        clkena,
  input  ber_types_pkg::frame_ctl_s   ctl,
  input  logic [bit_err_w-1:0]        biterr,
  output logic                        frame_val,
  output logic [err_w-1:0]            frame_err
);

  // lane count, rounded up
  localparam int lane_n = (bit_err_w + ber_cfg_pkg::LANE_W - 1) / ber_cfg_pkg::LANE_W;
  // vector width padded to whole lanes
  localparam int pad_w  = lane_n * ber_cfg_pkg::LANE_W;
  // tree depth and power-of-two input count
  localparam int depth  = $clog2(lane_n);
  localparam int tree_n = 2 ** depth;

  logic [pad_w-1:0]          biterr_pad;
  logic [err_w-1:0]          lane_err [lane_n];
  ber_types_pkg::frame_ctl_s lane_ctl;
  logic [err_w-1:0]          tree_err [tree_n];
  ber_types_pkg::frame_ctl_s tree_ctl;
  logic [err_w-1:0]          tree_sum;
  logic [err_w-1:0]          acc;
  logic [err_w-1:0]          acc_nxt;

  genvar g;

  // ------------------------------------------------------------
  // lane split and popcount
  // ------------------------------------------------------------

  // zero extend, top lane may be partial
  assign biterr_pad = pad_w'(biterr);

  for (g = 0; g < lane_n; g++) begin : g_lane
    // all lanes share timing, lane 0 carries the control
    if (g == 0) begin : g_ctl
      biterr_sum_36 #(.err_w(err_w)) u_sum (
        .iclk(iclk), .rst_n(rst_n), .clkena(clkena),
        .ctl_in(ctl), .lane(biterr_pad[g*ber_cfg_pkg::LANE_W +: ber_cfg_pkg::LANE_W]),
        .ctl_out(lane_ctl), .err(lane_err[g])
      );
    end else begin : g_data
      biterr_sum_36 #(.err_w(err_w)) u_sum (
        .iclk(iclk), .rst_n(rst_n), .clkena(clkena),
        .ctl_in(ctl), .lane(biterr_pad[g*ber_cfg_pkg::LANE_W +: ber_cfg_pkg::LANE_W]),
        .ctl_out(), .err(lane_err[g])
      );
    end
  end

  // ------------------------------------------------------------
  // adder tree
  // ------------------------------------------------------------

  // unused tree inputs tied to zero
  for (g = 0; g < tree_n; g++) begin : g_tree_in
    if (g < lane_n) begin : g_used
      assign tree_err[g] = lane_err[g];
    end else begin : g_zero
      assign tree_err[g] = '0;
    end
  end

  biterr_adder_tree #(.err_w(err_w), .depth(depth)) u_tree (
    .iclk(iclk), .rst_n(rst_n), .clkena(clkena),
    .ctl_in(lane_ctl), .err_in(tree_err),
    .ctl_out(tree_ctl), .sum(tree_sum)
  );

  // ------------------------------------------------------------
  // frame accumulator
  // ------------------------------------------------------------

  // sop restarts, anything else adds on
  assign acc_nxt = tree_ctl.sop ? tree_sum : acc + tree_sum;

  always_ff @(posedge iclk or negedge rst_n) begin
    if (!rst_n) begin
      frame_val <= 1'b0;
    end else if (clkena) begin
      frame_val <= tree_ctl.val & tree_ctl.eop;
    end
  end

  // running sum, result latched only on eop so it holds
  always_ff @(posedge iclk) begin
    if (clkena && tree_ctl.val) begin
      acc <= acc_nxt;
      if (tree_ctl.eop) begin
        frame_err <= acc_nxt;
      end
    end
  end

  // input framing rule, checked at the entry point
  a_ctl_in_qualified : assert property (
    @(posedge iclk) disable iff (!rst_n)
    (ctl.sop || ctl.eop) |-> ctl.val
  );

endmodule

// ==== logic/biterr_sum_36.sv ====
// one lane popcount, one register stage
// control is delayed to stay aligned with the count
module biterr_sum_36 #(
  parameter int err_w = 16
) (
  input  logic                                iclk,
  input  logic                                rst_n,
  input  logic                                clkena,
  input  ber_types_pkg::frame_ctl_s           ctl_in,
  input  logic [ber_cfg_pkg::LANE_W-1:0]      lane,
  output ber_types_pkg::frame_ctl_s           ctl_out,
  output logic [err_w-1:0]                    err
);

  // combinational bit count of the lane
  logic [err_w-1:0] cnt;

  // ------------------------------------------------------------
  // popcount
  // ------------------------------------------------------------

  always_comb begin
    cnt = '0;
    for (int i = 0; i < ber_cfg_pkg::LANE_W; i++) begin
      cnt = cnt + err_w'(lane[i]);
    end
  end

  // ------------------------------------------------------------
  // output registers
  // ------------------------------------------------------------

  // control stage, cleared on reset
  always_ff @(posedge iclk or negedge rst_n) begin
    if (!rst_n) begin
      ctl_out <= '0;
    end else if (clkena) begin
      ctl_out <= ctl_in;
    end
  end

  // count register, payload only
  always_ff @(posedge iclk) begin
    if (clkena) begin
      err <= cnt;
    end
  end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the ber meter testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ber_meter -f vlog.f -o tb_ber_meter

./obj_dir/tb_ber_meter > sim.log 2>&1 || true
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
  echo "simulation ended without a result, see sim.log"
  exit 1
fi
echo "simulation passed"

// ==== test/tb_ber_meter.sv ====
module tb_ber_meter;

  localparam int bit_w   = ber_cfg_pkg::DEF_BIT_ERR_W;
  localparam int err_w   = ber_cfg_pkg::DEF_ERR_W;
  localparam int total_w = ber_cfg_pkg::DEF_TOTAL_W;
  // eop word to frame_val, enabled cycles
  localparam int latency = 4;
  localparam int tmo     = 200;

  logic                      iclk;
  logic                      rst_n;
  logic                      clkena;
  logic                      clear;
  ber_types_pkg::frame_ctl_s ctl;
  logic [bit_w-1:0]          biterr;
  logic                      frame_val;
  logic [err_w-1:0]          frame_err;
  logic [total_w-1:0]        total_err;
  logic [total_w-1:0]        frame_cnt;

  // driver side model
  logic [31:0] rng = 32'h2d2f;
  int          en_cyc = 0;
  int          frame_acc = 0;
  int          exp_q[$];
  int          stamp_q[$];
  longint      sent_total = 0;
  longint      sent_frames = 0;
  // checker side model
  longint      exp_total = 0;
  longint      exp_frames = 0;
  bit          stats_pending = 1'b0;

  ber_meter_top #(.bit_err_w(bit_w), .err_w(err_w), .total_w(total_w)) dut0 (.*);

  initial begin
    iclk = 1'b0;
    forever #5 iclk = ~iclk;
  end

  // enabled cycle count, latency reference
  always @(posedge iclk) begin
    if (rst_n && clkena) begin
      en_cyc <= en_cyc + 1;
    end
  end

  // ------------------------------------------------------------
  // reference model and helpers
  // ------------------------------------------------------------

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  // expected errors of one word
  function automatic int count_ones(input logic [bit_w-1:0] v);
    int n;
    n = 0;
    for (int i = 0; i < bit_w; i++) begin
      if (v[i]) n++;
    end
    return n;
  endfunction

  task automatic rand_vec(output logic [bit_w-1:0] v);
    v = '0;
    for (int i = 0; i < (bit_w + 31) / 32; i++) begin
      rng = xorshift(rng);
      v = (v << 32) | bit_w'(rng);
    end
  endtask

  task automatic rand_below(input int n, output int r);
    rng = xorshift(rng);
    r = int'(rng % n);
  endtask

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input longint exp, input longint act);
    if (exp != act) begin
      report_failure($sformatf("Fail %s: expected %0d, actual %0d", name, exp, act));
    end
  endtask

  // one word on the falling edge, model follows the frame rules
  task automatic drive(input bit val, input bit sop, input bit eop,
                       input logic [bit_w-1:0] v);
    ctl = {val, sop, eop};
    biterr = v;
    clkena = 1'b1;
    if (val && sop) frame_acc = count_ones(v);
    else if (val) frame_acc += count_ones(v);
    if (val && eop) begin
      exp_q.push_back(frame_acc);
      stamp_q.push_back(en_cyc);
      sent_total += frame_acc;
      sent_frames++;
    end
    @(negedge iclk);
  endtask

  // frozen pipeline, junk start word must be ignored
  task automatic stall(input int n);
    clkena = 1'b0;
    ctl = {1'b1, 1'b1, 1'b0};
    rand_vec(biterr);
    repeat (n) @(negedge iclk);
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 || stats_pending) begin
      drive(1'b0, 1'b0, 1'b0, '0);
      n++;
      if (n > tmo) report_failure("outstanding frames never came out of the pipeline");
    end
  endtask

  task automatic clear_stats();
    clear = 1'b1;
    drive(1'b0, 1'b0, 1'b0, '0);
    clear = 1'b0;
    check_value("clear total_err", 0, total_err);
    check_value("clear frame_cnt", 0, frame_cnt);
    sent_total = 0;
    sent_frames = 0;
    exp_total = 0;
    exp_frames = 0;
  endtask

  task automatic wait_enabled(input int last);
    int n;
    n = 0;
    do begin
      @(negedge iclk);
      n++;
      if (n > tmo) report_failure("clock enable stayed low too long");
    end while (en_cyc == last);
  endtask

  // ------------------------------------------------------------
  // checker, one pass per enabled cycle
  // ------------------------------------------------------------

  initial begin : compare
    int last_en;
    int idle;
    int n;
    int exp_err;
    int stamp;
    idle = 0;
    n = 0;
    while (rst_n !== 1'b1) begin
      @(negedge iclk);
      n++;
      if (n > tmo) report_failure("reset was never released");
    end
    last_en = en_cyc;
    forever begin
      wait_enabled(last_en);
      last_en = en_cyc;
      // stats lag the result by one cycle
      if (stats_pending) begin
        check_value("total_err", exp_total, total_err);
        check_value("frame_cnt", exp_frames, frame_cnt);
        stats_pending = 1'b0;
      end
      if (frame_val) begin
        if (exp_q.size() == 0) begin
          report_failure("frame_val pulsed with no frame outstanding");
        end else begin
          exp_err = exp_q.pop_front();
          stamp = stamp_q.pop_front();
          check_value("frame_err", exp_err, frame_err);
          check_value("latency", latency, en_cyc - stamp);
          exp_total += exp_err;
          exp_frames++;
          stats_pending = 1'b1;
          idle = 0;
        end
      end else if (exp_q.size() != 0) begin
        idle++;
        if (idle > tmo) report_failure("timed out waiting for frame_val");
      end
    end
  end

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------

  initial begin : stimulus
    logic [bit_w-1:0] v;
    int len;
    int r;
    rst_n = 1'b0;
    clkena = 1'b0;
    clear = 1'b0;
    ctl = '0;
    biterr = '0;
    repeat (4) @(posedge iclk);
    @(negedge iclk);
    rst_n = 1'b1;
    // single-word frames
    for (int i = 0; i < 20; i++) begin
      rand_vec(v);
      drive(1'b1, 1'b1, 1'b1, v);
      rand_vec(v);
      drive(1'b0, 1'b0, 1'b0, v);
    end
    // multi-word frames with gaps
    for (int i = 0; i < 12; i++) begin
      // abandoned start, next sop discards it
      if (i % 3 == 0) begin
        rand_vec(v);
        drive(1'b1, 1'b1, 1'b0, v);
        rand_vec(v);
        drive(1'b1, 1'b0, 1'b0, v);
      end
      rand_below(6, len);
      for (int w = 0; w <= len; w++) begin
        rand_vec(v);
        drive(1'b1, w == 0, w == len, v);
        rand_below(2, r);
        if (r != 0) drive(1'b0, 1'b0, 1'b0, v);
      end
    end
    // back to back, several frames in flight
    for (int i = 0; i < 16; i++) begin
      for (int w = 0; w <= i % 3; w++) begin
        rand_vec(v);
        if (i % 4 == 0) v = '1;
        else if (i % 4 == 1) v = '0;
        drive(1'b1, w == 0, w == i % 3, v);
      end
    end
    // clock enable low mid-frame and with results in flight
    for (int i = 0; i < 6; i++) begin
      rand_vec(v);
      drive(1'b1, 1'b1, 1'b0, v);
      stall(3 + i);
      rand_vec(v);
      drive(1'b1, 1'b0, 1'b1, v);
      stall(i + 1);
    end
    drain();
    check_value("run total_err", sent_total, total_err);
    check_value("run frame_cnt", sent_frames, frame_cnt);
    // clear, then counting restarts
    clear_stats();
    for (int i = 0; i < 8; i++) begin
      rand_vec(v);
      drive(1'b1, 1'b1, 1'b1, v);
    end
    drain();
    check_value("restart total_err", sent_total, total_err);
    check_value("restart frame_cnt", sent_frames, frame_cnt);
    $display("=== PASS ===");
    $finish;
  end

endmodule

// ==== vlog.f ====
logic/ber_cfg_pkg.sv
logic/ber_types_pkg.sv
logic/biterr_sum_36.sv
logic/biterr_adder_tree.sv
logic/biterr_cnt.sv
logic/ber_stats.sv
logic/ber_meter_top.sv
test/tb_ber_meter.sv
